//--- common/memPkg.sv
package memPkg;

    localparam int addrWidth    = 32;
    localparam int ramAddrWidth = 16;

    typedef logic [addrWidth-1:0] memAddr_t;
    typedef logic [31:0]          memWord_t;
    typedef logic [7:0]           memByte_t;
    typedef logic [1:0]           memLen_t;

    // access length codes, 2'b00 is never a legal length
    localparam memLen_t lenIll = 2'b00;
    localparam memLen_t len1   = 2'b01;
    localparam memLen_t len2   = 2'b10;
    localparam memLen_t len4   = 2'b11;

    // bus owner
    localparam logic [1:0] ownIdle  = 2'd0;
    localparam logic [1:0] ownFetch = 2'd1;
    localparam logic [1:0] ownData  = 2'd2;

    // four address steps, then the done step
    localparam logic [2:0] fetchLastStage = 3'd5;

    // control transfer opcodes seen by predecode
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // filled byte by byte from memory, read back as instruction fields
    typedef union packed {
        memByte_t [3:0] bytes;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } fields;
    } instWord_u;

endpackage

//--- instFetchPort/instFetchPort.sv
`timescale 1ns/10ps

module instFetchPort (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetchStart,
    input  logic              step,
    input  memPkg::memAddr_t  fetchAddr,
    input  memPkg::memByte_t  ramRdData,
    output memPkg::memAddr_t  ramAddr,
    output logic              portLast,
    output logic              fetchDone,
    output memPkg::instWord_u fetchInst,
    output logic              bpEn,
    output memPkg::instWord_u bpInst
);
    import memPkg::*;

    logic [2:0] stage;
    logic [2:0] byteIdx;
    logic [2:0] rdIdx;
    memAddr_t   baseAddr;
    instWord_u  instBuf;
    instWord_u  instWord;
    logic       isCtrl;

    // address offset of the current stage
    assign byteIdx = stage - 3'd1;
    // byte returning from the previous stage
    assign rdIdx   = stage - 3'd2;

    assign ramAddr   = baseAddr + memAddr_t'(byteIdx[1:0]);
    assign portLast  = (stage == fetchLastStage);
    assign fetchDone = portLast && step;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= 3'd0;
        end else if (step) begin
            if (fetchStart) begin
                stage <= 3'd1;
            end else if (portLast) begin
                stage <= 3'd0;
            end else if (stage != 3'd0) begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            if (fetchStart) begin
                baseAddr <= fetchAddr;
            end
            if (stage >= 3'd2) begin
                instBuf.bytes[rdIdx[1:0]] <= ramRdData;
            end
        end
    end

    // top byte is still on the RAM output in the done cycle
    always_comb begin
        instWord          = instBuf;
        instWord.bytes[3] = ramRdData;
    end

    assign isCtrl = (instWord.fields.opcode == opBranch) ||
                    (instWord.fields.opcode == opJal) ||
                    (instWord.fields.opcode == opJalr);

    assign fetchInst = instWord;
    assign bpInst    = instWord;
    assign bpEn      = fetchDone && isCtrl;

    // arbiter only starts a fetch once the previous one has drained
    fetchStartIdle: assert property (
        @(posedge clk) disable iff (rst)
        fetchStart |-> stage == 3'd0
    );

endmodule

//--- dataPort/dataPort.sv
`timescale 1ns/10ps

module dataPort (
    input  logic             clk,
    input  logic             rst,
    input  logic             dataStart,
    input  logic             step,
    input  logic             dataStore,
    input  memPkg::memLen_t  dataLen,
    input  memPkg::memAddr_t dataAddr,
    input  memPkg::memWord_t dataWrData,
    input  memPkg::memByte_t ramRdData,
    output memPkg::memAddr_t ramAddr,
    output logic             ramWe,
    output memPkg::memByte_t ramWrData,
    output logic             portLast,
    output logic             dataDone,
    output memPkg::memWord_t dataRdData
);
    import memPkg::*;

    logic [2:0] stage;
    logic [2:0] nBytes;
    logic [2:0] byteIdx;
    logic [2:0] rdIdx;
    logic       active;
    logic       isStore;
    memAddr_t   baseAddr;
    memWord_t   wrBuf;
    memWord_t   rdBuf;

    function automatic logic [2:0] lenBytes(input memLen_t len);
        case (len)
            len1:    lenBytes = 3'd1;
            len2:    lenBytes = 3'd2;
            len4:    lenBytes = 3'd4;
            default: lenBytes = 3'd1;
        endcase
    endfunction

    assign active  = (stage != 3'd0);
    assign byteIdx = stage - 3'd1;
    assign rdIdx   = stage - 3'd2;

    // stores finish with the last write and loads one step later with the last byte
    assign portLast = active &&
                      (isStore ? (stage == nBytes) : (stage == nBytes + 3'd1));
    assign dataDone = portLast && step;

    assign ramAddr   = baseAddr + memAddr_t'(byteIdx[1:0]);
    assign ramWe     = isStore && active && step;
    assign ramWrData = wrBuf[8*byteIdx[1:0] +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= 3'd0;
        end else if (step) begin
            if (dataStart) begin
                stage <= 3'd1;
            end else if (portLast) begin
                stage <= 3'd0;
            end else if (active) begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            if (dataStart) begin
                baseAddr <= dataAddr;
                nBytes   <= lenBytes(dataLen);
                isStore  <= dataStore;
                wrBuf    <= dataWrData;
            end
            if (!isStore && stage >= 3'd2) begin
                rdBuf[8*rdIdx[1:0] +: 8] <= ramRdData;
            end
        end
    end

    // little endian with the last byte straight from the RAM and upper bytes zero
    always_comb begin
        dataRdData = '0;
        for (int i = 0; i < 4; i++) begin
            if (3'(i) + 3'd1 < nBytes) begin
                dataRdData[8*i +: 8] = rdBuf[8*i +: 8];
            end else if (3'(i) + 3'd1 == nBytes) begin
                dataRdData[8*i +: 8] = ramRdData;
            end
        end
    end

    lenLegal: assert property (
        @(posedge clk) disable iff (rst)
        dataStart && step |-> dataLen != lenIll
    );

endmodule

//--- verilog/busArbiter.sv
`timescale 1ns/10ps

module busArbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             ioFull,
    input  logic             fetchEn,
    input  logic             dataEn,
    input  logic             fetchLast,
    input  logic             dataLast,
    input  memPkg::memAddr_t fetchRamAddr,
    input  memPkg::memAddr_t dataRamAddr,
    input  logic             dataRamWe,
    input  memPkg::memByte_t dataRamWrData,
    output logic             fetchStart,
    output logic             dataStart,
    output logic             step,
    output memPkg::memAddr_t ramAddr,
    output logic             ramWe,
    output memPkg::memByte_t ramWrData
);
    import memPkg::*;

    logic [1:0] owner;
    memAddr_t   ownerAddr;
    memAddr_t   holdAddr;

    assign step = rdy && !ioFull;

    // start pulse first, the owner follows on the next step
    always_ff @(posedge clk) begin
        if (rst) begin
            owner      <= ownIdle;
            fetchStart <= 1'b0;
            dataStart  <= 1'b0;
        end else if (step) begin
            fetchStart <= 1'b0;
            dataStart  <= 1'b0;
            case (owner)
                ownIdle: begin
                    if (dataStart) begin
                        owner <= ownData;
                    end else if (fetchStart) begin
                        owner <= ownFetch;
                    end else if (dataEn) begin
                        dataStart <= 1'b1;
                    end else if (fetchEn) begin
                        fetchStart <= 1'b1;
                    end
                end
                ownFetch: begin
                    if (fetchLast) begin
                        owner <= ownIdle;
                    end
                end
                ownData: begin
                    if (dataLast) begin
                        owner <= ownIdle;
                    end
                end
                default: begin
                    owner <= ownIdle;
                end
            endcase
        end
    end

    assign ownerAddr = (owner == ownData) ? dataRamAddr : fetchRamAddr;

    // while stalled the RAM keeps reading the last stepped address,
    // so the byte a port expects is still there when it resumes
    always_ff @(posedge clk) begin
        if (step) begin
            holdAddr <= ownerAddr;
        end
    end

    assign ramAddr   = step ? ownerAddr : holdAddr;
    assign ramWe     = (owner == ownData) && step && dataRamWe;
    assign ramWrData = dataRamWrData;

    startOneHot: assert property (
        @(posedge clk) disable iff (rst)
        !(fetchStart && dataStart)
    );

    startWhenIdle: assert property (
        @(posedge clk) disable iff (rst)
        (fetchStart || dataStart) |-> owner == ownIdle
    );

endmodule

//--- verilog/byteRam.sv
`timescale 1ns/10ps

module byteRam (
    input  logic             clk,
    input  memPkg::memAddr_t ramAddr,
    input  logic             ramWe,
    input  memPkg::memByte_t ramWrData,
    output memPkg::memByte_t ramRdData
);
    import memPkg::*;

    memByte_t                mem [0:(1 << ramAddrWidth) - 1];
    logic [ramAddrWidth-1:0] idx;

    // only the low address bits reach the array
    assign idx = ramAddr[ramAddrWidth-1:0];

    initial begin
        for (int i = 0; i < (1 << ramAddrWidth); i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[idx] <= ramWrData;
        end
        ramRdData <= mem[idx];
    end

endmodule

//--- verilog/memCtrl.sv
`timescale 1ns/10ps

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioFull,
    input  logic              fetchEn,
    input  memPkg::memAddr_t  fetchAddr,
    output logic              fetchDone,
    output memPkg::instWord_u fetchInst,
    output logic              bpEn,
    output memPkg::instWord_u bpInst,
    input  logic              dataEn,
    input  logic              dataStore,
    input  memPkg::memLen_t   dataLen,
    input  memPkg::memAddr_t  dataAddr,
    input  memPkg::memWord_t  dataWrData,
    output logic              dataDone,
    output memPkg::memWord_t  dataRdData
);
    import memPkg::*;

    logic     fetchStart;
    logic     dataStart;
    logic     step;
    logic     fetchLast;
    logic     dataLast;
    memAddr_t fetchRamAddr;
    memAddr_t dataRamAddr;
    logic     dataRamWe;
    memByte_t dataRamWrData;
    memAddr_t ramAddr;
    logic     ramWe;
    memByte_t ramWrData;
    memByte_t ramRdData;

    instFetchPort u_fetch (
        .clk        (clk),
        .rst        (rst),
        .fetchStart (fetchStart),
        .step       (step),
        .fetchAddr  (fetchAddr),
        .ramRdData  (ramRdData),
        .ramAddr    (fetchRamAddr),
        .portLast   (fetchLast),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .bpEn       (bpEn),
        .bpInst     (bpInst)
    );

    dataPort u_data (
        .clk        (clk),
        .rst        (rst),
        .dataStart  (dataStart),
        .step       (step),
        .dataStore  (dataStore),
        .dataLen    (dataLen),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .ramRdData  (ramRdData),
        .ramAddr    (dataRamAddr),
        .ramWe      (dataRamWe),
        .ramWrData  (dataRamWrData),
        .portLast   (dataLast),
        .dataDone   (dataDone),
        .dataRdData (dataRdData)
    );

    busArbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .ioFull        (ioFull),
        .fetchEn       (fetchEn),
        .dataEn        (dataEn),
        .fetchLast     (fetchLast),
        .dataLast      (dataLast),
        .fetchRamAddr  (fetchRamAddr),
        .dataRamAddr   (dataRamAddr),
        .dataRamWe     (dataRamWe),
        .dataRamWrData (dataRamWrData),
        .fetchStart    (fetchStart),
        .dataStart     (dataStart),
        .step          (step),
        .ramAddr       (ramAddr),
        .ramWe         (ramWe),
        .ramWrData     (ramWrData)
    );

    byteRam u_ram (
        .clk       (clk),
        .ramAddr   (ramAddr),
        .ramWe     (ramWe),
        .ramWrData (ramWrData),
        .ramRdData (ramRdData)
    );

endmodule

//--- sim/clkGen.sv
`timescale 1ns/10ps

module clkGen (
    output logic clk,
    output logic rst
);
    localparam int halfPeriod = 4;
    localparam int rstCycles  = 10;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rstCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- sim/memCtrlTb.sv
`timescale 1ns/10ps

module memCtrlTb;
    import memPkg::*;

    localparam int nFill     = 16;
    localparam int nLoads    = 24;
    localparam int nStores   = 24;
    localparam int nPrio     = 8;
    localparam int nStallOps = 32;
    localparam int maxStall  = 3;
    localparam int opTimeout = 200;
    localparam int nOps      = 2*nFill + nLoads + 2*nStores + 2*nPrio + nStallOps;
    // about 8 cycles per op, and every one of them may follow a full stall run
    localparam longint watchNs = longint'(nOps) * 8 * (1 + maxStall) * 8 + 2000;

    logic      clk;
    logic      rst;
    logic      rdy;
    logic      ioFull;
    logic      fetchEn;
    memAddr_t  fetchAddr;
    logic      fetchDone;
    instWord_u fetchInst;
    logic      bpEn;
    instWord_u bpInst;
    logic      dataEn;
    logic      dataStore;
    memLen_t   dataLen;
    memAddr_t  dataAddr;
    memWord_t  dataWrData;
    logic      dataDone;
    memWord_t  dataRdData;

    memByte_t model [0:(1 << ramAddrWidth) - 1];
    integer   seed;
    int       errors;
    int       testsRun;
    int       stallRun;
    bit       stallOn;
    bit       timingOn;
    bit       fetchBusy;
    bit       dataBusy;

    clkGen u_clk (
        .clk (clk),
        .rst (rst)
    );

    memCtrl u_dut (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .ioFull     (ioFull),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .bpEn       (bpEn),
        .bpInst     (bpInst),
        .dataEn     (dataEn),
        .dataStore  (dataStore),
        .dataLen    (dataLen),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataDone   (dataDone),
        .dataRdData (dataRdData)
    );

    function automatic int lenCount(input memLen_t len);
        case (len)
            len1:    lenCount = 1;
            len2:    lenCount = 2;
            len4:    lenCount = 4;
            default: lenCount = 0;
        endcase
    endfunction

    function automatic logic [ramAddrWidth-1:0] ramIdx(input memAddr_t a);
        ramIdx = a[ramAddrWidth-1:0];
    endfunction

    function automatic memLen_t randLen();
        case ({$random(seed)} % 3)
            0:       randLen = len1;
            1:       randLen = len2;
            default: randLen = len4;
        endcase
    endfunction

    // random upper bits must not matter to the RAM
    function automatic memAddr_t randAddr(input int base, input int span);
        memAddr_t r;
        r        = $random(seed);
        randAddr = {r[31:16], 16'(base + {$random(seed)} % span)};
    endfunction

    task automatic checkWord(input string what, input memWord_t got, input memWord_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkInst(input string what, input instWord_u got, input instWord_u exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkCycles(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // cycles are counted in rising edges after the enable went up
    task automatic waitDone(input bit isData, output int cycles, output bit ok);
        cycles = 0;
        ok     = 1'b0;
        while (cycles < opTimeout && !ok) begin
            @(negedge clk);
            if ((isData ? dataDone : fetchDone) === 1'b1) begin
                ok = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        if (!ok) begin
            $display("%s never arrived within %0d cycles", isData ? "dataDone" : "fetchDone",
                     opTimeout);
            errors++;
        end
    endtask

    task automatic dropEnable(input bit isData);
        @(posedge clk);
        if (isData) begin
            dataEn   <= 1'b0;
            dataBusy = 1'b0;
        end else begin
            fetchEn   <= 1'b0;
            fetchBusy = 1'b0;
        end
    endtask

    task automatic doStore(input memAddr_t addr, input memLen_t len, input memWord_t wr);
        int cycles;
        bit ok;
        for (int i = 0; i < lenCount(len); i++) begin
            model[ramIdx(addr + memAddr_t'(i))] = wr[8*i +: 8];
        end
        @(posedge clk);
        dataEn     <= 1'b1;
        dataStore  <= 1'b1;
        dataLen    <= len;
        dataAddr   <= addr;
        dataWrData <= wr;
        dataBusy   = 1'b1;
        waitDone(1'b1, cycles, ok);
        if (ok && timingOn) begin
            checkCycles("store latency", cycles, lenCount(len) + 1);
        end
        dropEnable(1'b1);
    endtask

    task automatic doLoad(input memAddr_t addr, input memLen_t len, output time doneAt);
        memWord_t exp;
        int       cycles;
        bit       ok;
        exp = '0;
        for (int i = 0; i < lenCount(len); i++) begin
            exp[8*i +: 8] = model[ramIdx(addr + memAddr_t'(i))];
        end
        @(posedge clk);
        dataEn    <= 1'b1;
        dataStore <= 1'b0;
        dataLen   <= len;
        dataAddr  <= addr;
        dataBusy  = 1'b1;
        waitDone(1'b1, cycles, ok);
        doneAt = $time;
        if (ok) begin
            checkWord($sformatf("load of %0d at %h", lenCount(len), addr), dataRdData, exp);
            if (timingOn) begin
                checkCycles("load latency", cycles, lenCount(len) + 2);
            end
        end
        dropEnable(1'b1);
    endtask

    task automatic doFetch(input memAddr_t addr, output time doneAt);
        instWord_u exp;
        logic      expBp;
        int        cycles;
        bit        ok;
        for (int i = 0; i < 4; i++) begin
            exp.bytes[i] = model[ramIdx(addr + memAddr_t'(i))];
        end
        expBp = (exp.fields.opcode == opBranch) || (exp.fields.opcode == opJal) ||
                (exp.fields.opcode == opJalr);
        @(posedge clk);
        fetchEn   <= 1'b1;
        fetchAddr <= addr;
        fetchBusy = 1'b1;
        waitDone(1'b0, cycles, ok);
        doneAt = $time;
        if (ok) begin
            checkInst($sformatf("fetch at %h", addr), fetchInst, exp);
            checkFlag("bpEn", bpEn, expBp);
            if (expBp) begin
                checkInst("bpInst", bpInst, exp);
            end
            if (timingOn) begin
                checkCycles("fetch latency", cycles, 6);
            end
        end
        dropEnable(1'b0);
    endtask

    task automatic idleCheck();
        @(negedge clk);
        checkFlag("fetchDone while idle", fetchDone, 1'b0);
        checkFlag("bpEn while idle", bpEn, 1'b0);
        checkFlag("dataDone while idle", dataDone, 1'b0);
    endtask

    task automatic endTest(input string name, input int errBefore);
        testsRun++;
        $display("test %0d %s: %s", testsRun, name, (errors == errBefore) ? "passed" : "failed");
    endtask

    // stall runs are capped so every operation keeps moving
    always @(posedge clk) begin : stallDriver
        logic nextRdy;
        logic nextFull;
        nextRdy  = 1'b1;
        nextFull = 1'b0;
        if (stallOn && stallRun < maxStall) begin
            nextRdy  = ($random(seed) % 4) != 0;
            nextFull = ($random(seed) % 5) == 0;
        end
        stallRun = (nextRdy && !nextFull) ? 0 : stallRun + 1;
        rdy    <= nextRdy;
        ioFull <= nextFull;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if ((fetchDone === 1'b1 || dataDone === 1'b1) && !(rdy && !ioFull)) begin
                $display("a done pulse showed up at %0t ns while the core was stalled", $time);
                errors++;
            end
            if (dataDone === 1'b1 && !dataBusy) begin
                $display("dataDone pulsed at %0t ns with no load or store pending", $time);
                errors++;
            end
            if (fetchDone === 1'b1 && !fetchBusy) begin
                $display("fetchDone pulsed at %0t ns with no fetch pending", $time);
                errors++;
            end
        end
    end

    initial begin : watchdog
        #(watchNs);
        $display("watchdog expired after %0d ns, the run did not complete", watchNs);
        $display("Errors found");
        $finish;
    end

    initial begin : mainSeq
        memAddr_t  addr;
        memAddr_t  fAddr;
        memLen_t   len;
        instWord_u inst;
        time       tData;
        time       tFetch;
        int        errBefore;
        int        sel;

        seed       = 32'h2c4a;
        errors     = 0;
        testsRun   = 0;
        stallRun   = 0;
        stallOn    = 1'b0;
        timingOn   = 1'b1;
        rdy        = 1'b1;
        ioFull     = 1'b0;
        fetchEn    = 1'b0;
        fetchAddr  = '0;
        dataEn     = 1'b0;
        dataStore  = 1'b0;
        dataLen    = len4;
        dataAddr   = '0;
        dataWrData = '0;
        for (int i = 0; i < (1 << ramAddrWidth); i++) begin
            model[i] = 8'h00;
        end

        errBefore = errors;
        @(posedge clk);
        while (rst) begin
            idleCheck();
        end
        repeat (4) idleCheck();
        endTest("reset", errBefore);

        // instruction words live at 0x800, some of them control transfers
        errBefore = errors;
        for (int k = 0; k < nFill; k++) begin
            inst = $random(seed);
            case ({$random(seed)} % 4)
                0:       inst.fields.opcode = opBranch;
                1:       inst.fields.opcode = opJal;
                2:       inst.fields.opcode = opJalr;
                default: ;
            endcase
            doStore(memAddr_t'(32'h800 + 4*k), len4, inst);
        end
        for (int k = 0; k < nFill; k++) begin
            fAddr = memAddr_t'(32'h800 + 4*({$random(seed)} % nFill));
            doFetch(fAddr, tFetch);
        end
        endTest("fetch", errBefore);

        errBefore = errors;
        for (int k = 0; k < nLoads; k++) begin
            addr = randAddr(32'h800, 4*nFill - 3);
            len  = randLen();
            doLoad(addr, len, tData);
        end
        endTest("loads", errBefore);

        errBefore = errors;
        for (int k = 0; k < nStores; k++) begin
            addr = randAddr(32'h900, 64);
            len  = randLen();
            doStore(addr, len, $random(seed));
            doLoad(addr, len4, tData);
        end
        endTest("stores", errBefore);

        errBefore = errors;
        timingOn  = 1'b0;
        for (int k = 0; k < nPrio; k++) begin
            addr  = randAddr(32'h800, 4*nFill - 3);
            len   = randLen();
            fAddr = memAddr_t'(32'h800 + 4*({$random(seed)} % nFill));
            fork
                doLoad(addr, len, tData);
                doFetch(fAddr, tFetch);
            join
            if (!(tData < tFetch)) begin
                $display("fetchDone at %0t ns did not wait for dataDone at %0t ns", tFetch, tData);
                errors++;
            end
        end
        endTest("priority", errBefore);

        errBefore = errors;
        stallOn   = 1'b1;
        for (int k = 0; k < nStallOps; k++) begin
            sel = {$random(seed)} % 3;
            if (sel == 0) begin
                addr = randAddr(32'h900, 64);
                len  = randLen();
                doStore(addr, len, $random(seed));
            end else if (sel == 1) begin
                addr = randAddr(32'h800, 316);
                len  = randLen();
                doLoad(addr, len, tData);
            end else begin
                fAddr = memAddr_t'(32'h800 + 4*({$random(seed)} % nFill));
                doFetch(fAddr, tFetch);
            end
        end
        stallOn = 1'b0;
        repeat (maxStall + 2) @(posedge clk);
        endTest("stalls", errBefore);

        $display("%0d tests run, %0d errors", testsRun, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- memCtrl.f
common/memPkg.sv
instFetchPort/instFetchPort.sv
dataPort/dataPort.sv
verilog/busArbiter.sv
verilog/byteRam.sv
verilog/memCtrl.sv
sim/clkGen.sv
sim/memCtrlTb.sv
